/* filelist.f */
+incdir+rtl
+incdir+verif
rtl/rv_isa_pkg.sv
rtl/decode_pkg.sv
rtl/decode_pipe_reg.sv
rtl/op_decoder.sv
rtl/imm_gen.sv
rtl/rv_decode_top.sv
verif/tb_rv_decode.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_rv_decode
XLEN      ?= 64
SEED      ?= 69
LOG       ?= sim.log
OBJ_DIR   ?= obj_dir
FILELIST  ?= filelist.f

VFLAGS ?= --binary --timing --assert
PARAMS  = -GXLEN=$(XLEN) -GSEED=$(SEED)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) $(PARAMS) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP) $(PARAMS)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* verif/tb_ref_decode.svh */
`ifndef TB_REF_DECODE_SVH
`define TB_REF_DECODE_SVH

// Expected decode of one instruction word
function automatic decoded_instr_t ref_decode(input logic [63:0] pc, input logic [31:0] w,
                                              input int xlen);
    decoded_instr_t d;
    logic [6:0]  f7;
    logic [2:0]  f3;
    logic        rv32;
    logic        sra;
    logic [31:0] imm_i;
    logic [31:0] imm_u;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    f7    = w[31:25];
    f3    = w[14:12];
    rv32  = (xlen == 32);
    imm_i = {{20{w[31]}}, w[31:20]};
    imm_u = {w[31:12], 12'b0};
    imm_s = {{20{w[31]}}, w[31:25], w[11:7]};
    imm_b = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
    d     = '0;
    d.pc  = pc;
    case (w[6:0])
        7'h03: begin
            d.op_type     = MEM;
            d.rs1         = w[19:15];
            d.rd          = w[11:7];
            d.mem.size    = f3[1:0];
            d.mem.zeroext = f3[2];
            d.immediate   = imm_i;
            d.use_imm     = 1'b1;
            d.illegal     = (f3 == 3'b111) || (rv32 && (f3 == 3'b011 || f3 == 3'b110));
        end
        7'h23: begin
            d.op_type      = MEM;
            d.rs1          = w[19:15];
            d.rs2          = w[24:20];
            d.mem.is_store = 1'b1;
            d.mem.size     = f3[1:0];
            d.immediate    = imm_s;
            d.use_imm      = 1'b1;
            d.illegal      = f3[2] || (rv32 && f3 == 3'b011);
        end
        7'h0f: d.illegal = (f3 != 3'b000);
        7'h13: begin
            d.rs1       = w[19:15];
            d.rd        = w[11:7];
            d.immediate = imm_i;
            d.use_imm   = 1'b1;
            sra         = (w[31:26] == 6'b010000);
            case (f3)
                3'b010: begin
                    d.alu_op    = SCC;
                    d.condition = CC_LT;
                end
                3'b011: begin
                    d.alu_op    = SCC;
                    d.condition = CC_LTU;
                end
                3'b100: d.alu_op = XOR;
                3'b110: d.alu_op = OR;
                3'b111: d.alu_op = AND;
                3'b001: begin
                    d.alu_op     = SHIFT;
                    d.shift_left = 1'b1;
                    d.illegal    = (w[31:26] != 6'b0) || (rv32 && w[25]);
                end
                3'b101: begin
                    d.alu_op      = SHIFT;
                    d.shift_arith = sra;
                    d.illegal     = (w[31:26] != 6'b0 && !sra) || (rv32 && w[25]);
                end
                default: d.alu_op = ADD;
            endcase
        end
        7'h1b: begin
            d.immediate = imm_i;
            d.use_imm   = 1'b1;
            if (rv32) begin
                d.illegal = 1'b1;
            end else begin
                d.rs1   = w[19:15];
                d.rd    = w[11:7];
                d.is_32 = 1'b1;
                case (f3)
                    3'b000: d.alu_op = ADD;
                    3'b001: begin
                        d.alu_op     = SHIFT;
                        d.shift_left = 1'b1;
                        d.illegal    = (f7 != 7'h00);
                    end
                    3'b101: begin
                        d.alu_op      = SHIFT;
                        d.shift_arith = (f7 == 7'h20);
                        d.illegal     = (f7 != 7'h00 && f7 != 7'h20);
                    end
                    default: d.illegal = 1'b1;
                endcase
            end
        end
        7'h33, 7'h3b: begin
            d.rs1     = w[19:15];
            d.rs2     = w[24:20];
            d.rd      = w[11:7];
            d.is_32   = (w[6:0] == 7'h3b);
            d.illegal = rv32 && d.is_32;
            if (f7 == 7'h00) begin
                case (f3)
                    3'b001: begin
                        d.alu_op     = SHIFT;
                        d.shift_left = 1'b1;
                    end
                    3'b010: begin
                        d.alu_op    = SCC;
                        d.condition = CC_LT;
                    end
                    3'b011: begin
                        d.alu_op    = SCC;
                        d.condition = CC_LTU;
                    end
                    3'b100: d.alu_op = XOR;
                    3'b101: d.alu_op = SHIFT;
                    3'b110: d.alu_op = OR;
                    3'b111: d.alu_op = AND;
                    default: d.alu_op = ADD;
                endcase
            end else if (f7 == 7'h20 && f3 == 3'b000) begin
                d.alu_op = SUB;
            end else if (f7 == 7'h20 && f3 == 3'b101) begin
                d.alu_op      = SHIFT;
                d.shift_arith = 1'b1;
            end else begin
                d.illegal = 1'b1;
            end
            // ADDW, SUBW, SLLW, SRLW and SRAW are the only word encodings
            if (d.is_32 && f3 != 3'b000 && f3 != 3'b001 && f3 != 3'b101) begin
                d.illegal = 1'b1;
            end
        end
        7'h37, 7'h17: begin
            d.rd        = w[11:7];
            d.use_pc    = w[5] ? 1'b0 : 1'b1;
            d.immediate = imm_u;
            d.use_imm   = 1'b1;
        end
        7'h63: begin
            d.op_type   = BRANCH;
            d.rs1       = w[19:15];
            d.rs2       = w[24:20];
            d.use_pc    = 1'b1;
            d.immediate = imm_b;
            case (f3)
                3'b000: d.condition = CC_EQ;
                3'b001: d.condition = CC_NE;
                3'b100: d.condition = CC_LT;
                3'b101: d.condition = CC_GE;
                3'b110: d.condition = CC_LTU;
                3'b111: d.condition = CC_GEU;
                default: d.illegal = 1'b1;
            endcase
        end
        7'h6f: begin
            d.op_type   = BRANCH;
            d.rd        = w[11:7];
            d.use_pc    = 1'b1;
            d.condition = CC_TRUE;
            d.immediate = imm_j;
        end
        7'h67: begin
            d.op_type   = BRANCH;
            d.rs1       = w[19:15];
            d.rd        = w[11:7];
            d.condition = CC_TRUE;
            d.immediate = imm_i;
            d.use_imm   = 1'b1;
            d.illegal   = (f3 != 3'b000);
        end
        default: d.illegal = 1'b1;
    endcase
    return d;
endfunction

`endif

/* verif/tb_rv_decode.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module tb_rv_decode
    import rv_isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int XLEN = `RV_XLEN,
    parameter int SEED = 69
);

    `include "tb_ref_decode.svh"

    localparam int N_RANDOM = 2000;

    logic           clk;
    logic           rst_n;
    logic           in_valid;
    fetched_instr_t in_instr;
    logic           out_valid;
    decoded_instr_t out_instr;

    int             seed;
    int             cycle;
    logic [31:0]    sent;
    logic [31:0]    recv;
    logic [63:0]    pc_next;
    logic [31:0]    dir_q[$];
    logic           dir_ready;
    decoded_instr_t exp_q[$];
    int             due_q[$];

    // Opcodes swept with every funct3/funct7 pair, including rejected ones
    logic [6:0] sweep_ops[16] = '{7'h03, 7'h23, 7'h13, 7'h1b, 7'h33, 7'h3b, 7'h63, 7'h67,
                                  7'h0f, 7'h73, 7'h2f, 7'h37, 7'h17, 7'h6f, 7'h7f, 7'h00};
    logic [6:0] sweep_f7[5]  = '{7'h00, 7'h20, 7'h01, 7'h02, 7'h40};
    logic [6:0] imm_ops[9]   = '{7'h03, 7'h13, 7'h1b, 7'h67, 7'h37, 7'h17, 7'h23, 7'h63,
                                 7'h6f};
    logic [6:0] kept_ops[12] = '{7'h03, 7'h23, 7'h13, 7'h1b, 7'h33, 7'h3b, 7'h63, 7'h67,
                                 7'h0f, 7'h37, 7'h17, 7'h6f};

    rv_decode_top #(.XLEN(XLEN)) dut_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_instr  (in_instr),
        .out_valid (out_valid),
        .out_instr (out_instr)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) cycle = cycle + 1;

    task automatic stop_on(input string what);
        $display("%s at time %0t", what, $time);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] got,
                                   input logic [63:0] exp);
        $display("CHECK FAILED time=%0t signal=%s got=%h expected=%h", $time, name, got, exp);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_decoded(input decoded_instr_t got, input decoded_instr_t exp);
        if (got.pc !== exp.pc) report_mismatch("pc", got.pc, exp.pc);
        if (got.op_type !== exp.op_type) report_mismatch("op_type", got.op_type, exp.op_type);
        if (got.alu_op !== exp.alu_op) report_mismatch("alu_op", got.alu_op, exp.alu_op);
        if (got.shift_left !== exp.shift_left)
            report_mismatch("shift_left", got.shift_left, exp.shift_left);
        if (got.shift_arith !== exp.shift_arith)
            report_mismatch("shift_arith", got.shift_arith, exp.shift_arith);
        if (got.condition !== exp.condition)
            report_mismatch("condition", got.condition, exp.condition);
        if (got.is_32 !== exp.is_32) report_mismatch("is_32", got.is_32, exp.is_32);
        if (got.use_pc !== exp.use_pc) report_mismatch("use_pc", got.use_pc, exp.use_pc);
        if (got.use_imm !== exp.use_imm) report_mismatch("use_imm", got.use_imm, exp.use_imm);
        if (got.rs1 !== exp.rs1) report_mismatch("rs1", got.rs1, exp.rs1);
        if (got.rs2 !== exp.rs2) report_mismatch("rs2", got.rs2, exp.rs2);
        if (got.rd !== exp.rd) report_mismatch("rd", got.rd, exp.rd);
        if (got.mem !== exp.mem) report_mismatch("mem", got.mem, exp.mem);
        if (got.immediate !== exp.immediate)
            report_mismatch("immediate", got.immediate, exp.immediate);
        if (got.illegal !== exp.illegal) report_mismatch("illegal", got.illegal, exp.illegal);
    endtask

    task automatic check_valid_count(input string name, input logic [31:0] got,
                                     input logic [31:0] exp);
        if (got !== exp) report_mismatch(name, got, exp);
    endtask

    task automatic drive_word(input logic [31:0] w);
        @(posedge clk);
        #1;
        in_valid            = 1'b1;
        in_instr.pc         = pc_next;
        in_instr.instr_word = w;
        pc_next             = pc_next + 64'd4;
        sent                = sent + 1;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #1;
        in_valid = 1'b0;
    endtask

    // Sampled mid-cycle, where both the inputs and the registered outputs are settled
    always @(negedge clk) begin
        decoded_instr_t e;
        int             due;
        if (cycle >= 1) begin
            if ($isunknown(out_valid)) stop_on("out_valid is unknown");
            if (!rst_n && out_valid) stop_on("out_valid is high during reset");
            if (out_valid) begin
                if (exp_q.size() == 0) stop_on("out_valid came with no instruction pending");
                e   = exp_q.pop_front();
                due = due_q.pop_front();
                if (due != cycle) report_mismatch("out_valid cycle", cycle, due);
                check_decoded(out_instr, e);
                recv = recv + 1;
            end else if (due_q.size() > 0 && due_q[0] <= cycle) begin
                stop_on("an expected out_valid did not appear");
            end
            if (in_valid === 1'b1) begin
                exp_q.push_back(ref_decode(in_instr.pc, in_instr.instr_word, XLEN));
                due_q.push_back(cycle + 2);
            end
        end
    end

    initial begin
        int limit;
        wait (dir_ready);
        // Every random word may be followed by one idle cycle
        limit = dir_q.size() + 2 * N_RANDOM + 50;
        #(limit * 10);
        $display("Timeout after %0d cycles with %0d of %0d outputs seen", limit, recv, sent);
        $display("ERRORS FOUND");
        $fatal(1, "simulation stopped");
    end

    initial begin
        logic [31:0] r;
        logic [31:0] w;
        seed      = SEED;
        cycle     = 0;
        sent      = '0;
        recv      = '0;
        pc_next   = 64'h0000_0000_8000_0000;
        dir_ready = 1'b0;
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_instr  = '0;

        foreach (sweep_ops[o]) begin
            for (int f3 = 0; f3 < 8; f3++) begin
                foreach (sweep_f7[k]) begin
                    r = $random(seed);
                    dir_q.push_back({sweep_f7[k], r[14:5], 3'(f3), r[4:0], sweep_ops[o]});
                end
            end
        end
        // All ones, sign bit alone and zero above the opcode
        foreach (imm_ops[o]) begin
            dir_q.push_back({25'h1ff_ffff, imm_ops[o]});
            dir_q.push_back({25'h100_0000, imm_ops[o]});
            dir_q.push_back({25'h000_0000, imm_ops[o]});
        end
        dir_ready = 1'b1;

        repeat (2) @(posedge clk);
        #1;
        rst_n = 1'b1;
        repeat (3) drive_idle();

        foreach (dir_q[i]) drive_word(dir_q[i]);
        drive_idle();

        for (int i = 0; i < N_RANDOM; i++) begin
            w = $random(seed);
            r = $random(seed);
            if (r[1:0] != 2'b00) w[6:0] = kept_ops[r[7:4] % 12];
            drive_word(w);
            if (r[10:8] == 3'b000) drive_idle();
        end
        repeat (4) drive_idle();

        check_valid_count("output count", recv, sent);
        if (exp_q.size() == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("%0d decoded results never arrived", exp_q.size());
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

/* rtl/rv_decode_top.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module rv_decode_top
    import decode_pkg::*;
#(
    parameter int XLEN = `RV_XLEN
) (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           in_valid,
    input  fetched_instr_t in_instr,
    output logic           out_valid,
    output decoded_instr_t out_instr
);

    logic                 fetch_valid;
    fetched_instr_t       fetch_q;
    dec_ctrl_t            ctrl;
    logic [`RV_IMM_W-1:0] immediate;
    logic                 use_imm;
    decoded_instr_t       dec_d;

    decode_pipe_reg #(.payload_t(fetched_instr_t)) in_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_data   (in_instr),
        .out_valid (fetch_valid),
        .out_data  (fetch_q)
    );

    op_decoder #(.XLEN(XLEN)) op_decoder_i (
        .instr (fetch_q.instr_word),
        .ctrl  (ctrl)
    );

    imm_gen imm_gen_i (
        .instr     (fetch_q.instr_word),
        .immediate (immediate),
        .use_imm   (use_imm)
    );

    assign dec_d = '{
        pc:          fetch_q.pc,
        op_type:     ctrl.op_type,
        alu_op:      ctrl.alu_op,
        shift_left:  ctrl.shift_left,
        shift_arith: ctrl.shift_arith,
        condition:   ctrl.condition,
        is_32:       ctrl.is_32,
        use_pc:      ctrl.use_pc,
        use_imm:     use_imm,
        rs1:         ctrl.rs1,
        rs2:         ctrl.rs2,
        rd:          ctrl.rd,
        mem:         ctrl.mem,
        immediate:   immediate,
        illegal:     ctrl.illegal
    };

    decode_pipe_reg #(.payload_t(decoded_instr_t)) out_reg_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (fetch_valid),
        .in_data   (dec_d),
        .out_valid (out_valid),
        .out_data  (out_instr)
    );

endmodule

/* rtl/imm_gen.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module imm_gen
    import rv_isa_pkg::*;
(
    input  instr_word_t          instr,
    output logic [`RV_IMM_W-1:0] immediate,
    output logic                 use_imm
);

    localparam int IMM_W = `RV_IMM_W;

    imm_fmt_e fmt;

    always_comb begin
        unique case (instr.opcode)
            OPCODE_LOAD, OPCODE_OP_IMM, OPCODE_OP_IMM_32, OPCODE_JALR: fmt = IMM_I;
            OPCODE_LUI, OPCODE_AUIPC: fmt = IMM_U;
            OPCODE_STORE: fmt = IMM_S;
            OPCODE_BRANCH: fmt = IMM_B;
            OPCODE_JAL: fmt = IMM_J;
            default: fmt = IMM_NONE;
        endcase
    end

    // Branch and jump offsets go to the PC adder, not the ALU operand
    assign use_imm = (fmt == IMM_I) || (fmt == IMM_U) || (fmt == IMM_S);

    // Bit 31 of the word is the sign in every format
    always_comb begin
        unique case (fmt)
            IMM_I: begin
                immediate = IMM_W'(signed'({instr.funct7, instr.rs2}));
            end
            IMM_U: begin
                immediate = IMM_W'(signed'({instr.funct7, instr.rs2, instr.rs1,
                                            instr.funct3, 12'b0}));
            end
            IMM_S: begin
                immediate = IMM_W'(signed'({instr.funct7, instr.rd}));
            end
            IMM_B: begin
                immediate = IMM_W'(signed'({instr.funct7[6], instr.rd[0],
                                            instr.funct7[5:0], instr.rd[4:1], 1'b0}));
            end
            IMM_J: begin
                immediate = IMM_W'(signed'({instr.funct7[6], instr.rs1, instr.funct3,
                                            instr.rs2[0], instr.funct7[5:0],
                                            instr.rs2[4:1], 1'b0}));
            end
            default: immediate = '0;
        endcase
    end

endmodule

/* rtl/op_decoder.sv */
`timescale 1ns/1ps
`include "decode_consts.svh"

module op_decoder
    import rv_isa_pkg::*;
    import decode_pkg::*;
#(
    parameter int XLEN = `RV_XLEN
) (
    input  instr_word_t instr,
    output dec_ctrl_t   ctrl
);

    if (XLEN != 32 && XLEN != 64) begin : g_xlen_check
        $error("op_decoder supports only RV32I and RV64I");
    end

    always_comb begin
        ctrl           = '0;
        ctrl.op_type   = ALU;
        ctrl.alu_op    = ADD;
        ctrl.condition = CC_EQ;

        unique case (instr.opcode)
            OPCODE_LOAD: begin
                ctrl.op_type     = MEM;
                ctrl.rs1         = instr.rs1;
                ctrl.rd          = instr.rd;
                ctrl.mem.size    = instr.funct3[1:0];
                ctrl.mem.zeroext = instr.funct3[2];
                if (instr.funct3 == 3'b111) begin
                    ctrl.illegal = 1'b1;
                end
                // LD and LWU need a 64-bit base
                if (XLEN == 32 && (instr.funct3[1:0] == 2'b11 || instr.funct3 == 3'b110)) begin
                    ctrl.illegal = 1'b1;
                end
            end

            OPCODE_STORE: begin
                ctrl.op_type      = MEM;
                ctrl.rs1          = instr.rs1;
                ctrl.rs2          = instr.rs2;
                ctrl.mem.is_store = 1'b1;
                ctrl.mem.size     = instr.funct3[1:0];
                if (instr.funct3[2] || (XLEN == 32 && instr.funct3[1:0] == 2'b11)) begin
                    ctrl.illegal = 1'b1;
                end
            end

            // FENCE goes down the pipe as a NOP
            OPCODE_MISC_MEM: begin
                if (instr.funct3 != 3'b000) begin
                    ctrl.illegal = 1'b1;
                end
            end

            OPCODE_OP_IMM: begin
                ctrl.rs1 = instr.rs1;
                ctrl.rd  = instr.rd;
                unique case (instr.funct3)
                    3'b000: ctrl.alu_op = ADD;
                    3'b010: begin
                        ctrl.alu_op    = SCC;
                        ctrl.condition = CC_LT;
                    end
                    3'b011: begin
                        ctrl.alu_op    = SCC;
                        ctrl.condition = CC_LTU;
                    end
                    3'b100: ctrl.alu_op = XOR;
                    3'b110: ctrl.alu_op = OR;
                    3'b111: ctrl.alu_op = AND;
                    3'b001: begin
                        ctrl.alu_op     = SHIFT;
                        ctrl.shift_left = 1'b1;
                        // funct7[0] is shamt[5]
                        if (instr.funct7[6:1] != 6'b0 || (XLEN == 32 && instr.funct7[0])) begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                    default: begin
                        ctrl.alu_op = SHIFT;
                        if (instr.funct7[6:1] == 6'b010000) begin
                            ctrl.shift_arith = 1'b1;
                        end else if (instr.funct7[6:1] != 6'b0) begin
                            ctrl.illegal = 1'b1;
                        end
                        if (XLEN == 32 && instr.funct7[0]) begin
                            ctrl.illegal = 1'b1;
                        end
                    end
                endcase
            end

            OPCODE_OP_IMM_32: begin
                if (XLEN == 32) begin
                    ctrl.illegal = 1'b1;
                end else begin
                    ctrl.rs1   = instr.rs1;
                    ctrl.rd    = instr.rd;
                    ctrl.is_32 = 1'b1;
                    unique case (instr.funct3)
                        3'b000: ctrl.alu_op = ADD;
                        3'b001: begin
                            ctrl.alu_op     = SHIFT;
                            ctrl.shift_left = 1'b1;
                            if (instr.funct7 != F7_BASE) begin
                                ctrl.illegal = 1'b1;
                            end
                        end
                        3'b101: begin
                            ctrl.alu_op = SHIFT;
                            if (instr.funct7 == F7_ALT) begin
                                ctrl.shift_arith = 1'b1;
                            end else if (instr.funct7 != F7_BASE) begin
                                ctrl.illegal = 1'b1;
                            end
                        end
                        default: ctrl.illegal = 1'b1;
                    endcase
                end
            end

            OPCODE_OP, OPCODE_OP_32: begin
                ctrl.rs1   = instr.rs1;
                ctrl.rs2   = instr.rs2;
                ctrl.rd    = instr.rd;
                ctrl.is_32 = (instr.opcode == OPCODE_OP_32);
                if (instr.opcode == OPCODE_OP_32 && XLEN == 32) begin
                    ctrl.illegal = 1'b1;
                end
                unique casez ({instr.funct7, instr.funct3})
                    {F7_BASE, 3'b000}: ctrl.alu_op = ADD;
                    {F7_ALT,  3'b000}: ctrl.alu_op = SUB;
                    {F7_BASE, 3'b001}: begin
                        ctrl.alu_op     = SHIFT;
                        ctrl.shift_left = 1'b1;
                    end
                    {F7_BASE, 3'b101}: ctrl.alu_op = SHIFT;
                    {F7_ALT,  3'b101}: begin
                        ctrl.alu_op      = SHIFT;
                        ctrl.shift_arith = 1'b1;
                    end
                    {F7_BASE, 3'b010}, {F7_BASE, 3'b011}: begin
                        ctrl.alu_op    = SCC;
                        ctrl.condition = instr.funct3[0] ? CC_LTU : CC_LT;
                    end
                    {F7_BASE, 3'b100}: ctrl.alu_op = XOR;
                    {F7_BASE, 3'b110}: ctrl.alu_op = OR;
                    {F7_BASE, 3'b111}: ctrl.alu_op = AND;
                    // No M extension in this core
                    {F7_MULDIV, 3'b???}: ctrl.illegal = 1'b1;
                    default: ctrl.illegal = 1'b1;
                endcase
                // Word forms exist only for add, sub and shifts
                if (ctrl.is_32 && ctrl.alu_op != ADD && ctrl.alu_op != SUB
                        && ctrl.alu_op != SHIFT) begin
                    ctrl.illegal = 1'b1;
                end
            end

            OPCODE_LUI: begin
                ctrl.rd = instr.rd;
            end

            OPCODE_AUIPC: begin
                ctrl.rd     = instr.rd;
                ctrl.use_pc = 1'b1;
            end

            OPCODE_BRANCH: begin
                ctrl.op_type = BRANCH;
                ctrl.rs1     = instr.rs1;
                ctrl.rs2     = instr.rs2;
                ctrl.use_pc  = 1'b1;
                unique case (instr.funct3)
                    3'b000: ctrl.condition = CC_EQ;
                    3'b001: ctrl.condition = CC_NE;
                    3'b100: ctrl.condition = CC_LT;
                    3'b101: ctrl.condition = CC_GE;
                    3'b110: ctrl.condition = CC_LTU;
                    3'b111: ctrl.condition = CC_GEU;
                    default: ctrl.illegal = 1'b1;
                endcase
            end

            OPCODE_JAL: begin
                ctrl.op_type   = BRANCH;
                ctrl.rd        = instr.rd;
                ctrl.use_pc    = 1'b1;
                ctrl.condition = CC_TRUE;
            end

            OPCODE_JALR: begin
                ctrl.op_type   = BRANCH;
                ctrl.rs1       = instr.rs1;
                ctrl.rd        = instr.rd;
                ctrl.condition = CC_TRUE;
                if (instr.funct3 != 3'b000) begin
                    ctrl.illegal = 1'b1;
                end
            end

            // Known to the ISA but not handled here
            OPCODE_SYSTEM, OPCODE_AMO: ctrl.illegal = 1'b1;

            default: ctrl.illegal = 1'b1;
        endcase
    end

endmodule

/* rtl/decode_pipe_reg.sv */
`timescale 1ns/1ps

module decode_pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    input  payload_t in_data,
    output logic     out_valid,
    output payload_t out_data
);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    // Payload only moves with a valid strobe
    always_ff @(posedge clk) begin
        if (in_valid) begin
            out_data <= in_data;
        end
    end

    // Downstream stages rely on a clean valid once running
    a_valid_known: assert property (
        @(posedge clk) disable iff (!rst_n) !$isunknown(out_valid)
    );

    // Nothing leaves the stage in the cycle after a reset cycle
    a_valid_after_reset: assert property (
        @(posedge clk) !rst_n |=> !out_valid
    );

endmodule

/* rtl/decode_pkg.sv */
`include "decode_consts.svh"

package decode_pkg;
    import rv_isa_pkg::*;

    typedef struct packed {
        logic [`RV_PC_W-1:0] pc;
        instr_word_t         instr_word;
    } fetched_instr_t;

    // Execution unit that takes the instruction
    typedef enum logic [1:0] {
        ALU,
        MEM,
        BRANCH
    } op_type_e;

    typedef enum logic [2:0] {
        ADD,
        SUB,
        SCC,
        XOR,
        OR,
        AND,
        SHIFT
    } alu_op_e;

    // Compare condition, shared by set-less-than and branches
    typedef enum logic [2:0] {
        CC_EQ,
        CC_NE,
        CC_LT,
        CC_GE,
        CC_LTU,
        CC_GEU,
        CC_TRUE
    } cond_e;

    typedef struct packed {
        logic       is_store;
        logic [1:0] size;
        logic       zeroext;
    } mem_ctrl_t;

    // Control fields from the opcode decoder; use_imm comes from imm_gen
    typedef struct packed {
        op_type_e             op_type;
        alu_op_e              alu_op;
        logic                 shift_left;
        logic                 shift_arith;
        cond_e                condition;
        logic                 is_32;
        logic                 use_pc;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        mem_ctrl_t            mem;
        logic                 illegal;
    } dec_ctrl_t;

    typedef struct packed {
        logic [`RV_PC_W-1:0]  pc;
        op_type_e             op_type;
        alu_op_e              alu_op;
        logic                 shift_left;
        logic                 shift_arith;
        cond_e                condition;
        logic                 is_32;
        logic                 use_pc;
        logic                 use_imm;
        logic [`RV_REG_W-1:0] rs1;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rd;
        mem_ctrl_t            mem;
        logic [`RV_IMM_W-1:0] immediate;
        logic                 illegal;
    } decoded_instr_t;

endpackage

/* rtl/rv_isa_pkg.sv */
`include "decode_consts.svh"

package rv_isa_pkg;

    // Major opcodes in bits [6:0], base integer set plus the ones rejected by decode
    typedef enum logic [6:0] {
        OPCODE_LOAD      = 7'b0000011,
        OPCODE_MISC_MEM  = 7'b0001111,
        OPCODE_OP_IMM    = 7'b0010011,
        OPCODE_AUIPC     = 7'b0010111,
        OPCODE_OP_IMM_32 = 7'b0011011,
        OPCODE_STORE     = 7'b0100011,
        OPCODE_AMO       = 7'b0101111,
        OPCODE_OP        = 7'b0110011,
        OPCODE_LUI       = 7'b0110111,
        OPCODE_OP_32     = 7'b0111011,
        OPCODE_BRANCH    = 7'b1100011,
        OPCODE_JALR      = 7'b1100111,
        OPCODE_JAL       = 7'b1101111,
        OPCODE_SYSTEM    = 7'b1110011
    } opcode_e;

    // funct7 patterns of register-register ops
    typedef enum logic [6:0] {
        F7_BASE   = 7'b0000000,
        F7_MULDIV = 7'b0000001,
        F7_ALT    = 7'b0100000
    } funct7_e;

    // Immediate layouts of the base formats
    typedef enum logic [2:0] {
        IMM_NONE,
        IMM_I,
        IMM_U,
        IMM_S,
        IMM_B,
        IMM_J
    } imm_fmt_e;

    // Raw R-type field split of a 32-bit instruction word
    typedef struct packed {
        logic [6:0]           funct7;
        logic [`RV_REG_W-1:0] rs2;
        logic [`RV_REG_W-1:0] rs1;
        logic [2:0]           funct3;
        logic [`RV_REG_W-1:0] rd;
        opcode_e              opcode;
    } instr_word_t;

endpackage

/* rtl/decode_consts.svh */
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Base ISA width, 32 selects RV32I
`define RV_XLEN 64

// Decoded immediates are always this wide, whatever XLEN is
`define RV_IMM_W 32

// Architectural register index
`define RV_REG_W 5

// Program counter carried along with each instruction
`define RV_PC_W 64

`endif
